//--- sources.f
verilog/prv_pkg.sv
verilog/prv_int_arbiter.sv
verilog/prv_ex_arbiter.sv
verilog/prv_trap_ctrl.sv
verilog/prv_block.sv
tests/prv_block_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the trap unit testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project root"
  exit 1
fi

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=prv_block_tb_sim

verilator --binary --timing --assert \
  -f sources.f \
  --top-module prv_block_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
fi

grep -q -x "Testbench passed" "$LOG_FILE"
if [ $? -ne 0 ]; then
  echo "pass message not found in $LOG_FILE"
  exit 1
fi

echo "simulation passed"
exit 0

//--- tests/prv_block_tb.sv
//############################################################################
// Testbench for the machine-mode trap unit.
// Drives LFSR-based random traffic into the unit, keeps a reference model
// of the trap CSRs and compares trap, vectors and CSR reads every cycle.
//############################################################################

`default_nettype none

module prv_block_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          NUM_CYCLES = 3000;
  localparam int          MARGIN     = 100;
  localparam int          CLK_PERIOD = 10;
  localparam logic [15:0] SEED       = 16'd40124;
  localparam logic [31:0] IRQ_MASK   = 32'h0000_0888;  // mie bits 3, 7 and 11.

  logic        clk = 1'b0;
  logic        rst;
  logic [2:0]  int_lines;   // Timer in bit 0, software in bit 1, external in bit 2.
  logic [8:0]  ex_strobes;  // Load fault in bit 8 down to insn misaligned in bit 0.
  logic [31:0] pc;
  logic [31:0] bad_addr;
  logic        ret;
  logic        csr_we;
  logic [11:0] csr_addr;
  logic [31:0] csr_wdata;
  logic        trap;
  logic [31:0] trap_vector;
  logic [31:0] ret_target;
  logic [31:0] csr_rdata;

  logic [15:0] lfsr;

  // Reference copies of the trap CSRs.
  logic        m_gie;
  logic        m_mpie;
  logic [31:0] m_mie;
  logic [31:0] m_mip;
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [31:0] m_mtval;

  prv_block dut_i (
    .clk          (clk),
    .rst          (rst),
    .timer_int    (int_lines[0]),
    .soft_int     (int_lines[1]),
    .ext_int      (int_lines[2]),
    .fault_l      (ex_strobes[8]),
    .mal_l        (ex_strobes[7]),
    .fault_s      (ex_strobes[6]),
    .mal_s        (ex_strobes[5]),
    .breakpoint   (ex_strobes[4]),
    .env_m        (ex_strobes[3]),
    .illegal_insn (ex_strobes[2]),
    .fault_insn   (ex_strobes[1]),
    .mal_insn     (ex_strobes[0]),
    .pc           (pc),
    .bad_addr     (bad_addr),
    .ret          (ret),
    .csr_we       (csr_we),
    .csr_addr     (csr_addr),
    .csr_wdata    (csr_wdata),
    .trap         (trap),
    .trap_vector  (trap_vector),
    .ret_target   (ret_target),
    .csr_rdata    (csr_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [11:0] csr_addr_of(input logic [2:0] idx);
    case (idx)
      3'd0:    return prv_pkg::CSR_MSTATUS;
      3'd1:    return prv_pkg::CSR_MIE;
      3'd2:    return prv_pkg::CSR_MTVEC;
      3'd3:    return prv_pkg::CSR_MEPC;
      3'd4:    return prv_pkg::CSR_MCAUSE;
      3'd5:    return prv_pkg::CSR_MTVAL;
      3'd6:    return prv_pkg::CSR_MIP;
      default: return 12'h7C0;  // No trap CSR lives here.
    endcase
  endfunction

  function automatic logic [3:0] ex_code_of(input int idx);
    case (idx)
      8:       return prv_pkg::CAUSE_LOAD_FAULT;
      7:       return prv_pkg::CAUSE_LOAD_MAL;
      6:       return prv_pkg::CAUSE_STORE_FAULT;
      5:       return prv_pkg::CAUSE_STORE_MAL;
      4:       return prv_pkg::CAUSE_BREAKPOINT;
      3:       return prv_pkg::CAUSE_ECALL_M;
      2:       return prv_pkg::CAUSE_ILLEGAL;
      1:       return prv_pkg::CAUSE_INSN_FAULT;
      default: return prv_pkg::CAUSE_INSN_MAL;
    endcase
  endfunction

  // Works out whether the current inputs and model state take a trap.
  task automatic predict_trap(output logic hit, output logic [31:0] cause,
                              output logic [31:0] epc, output logic [31:0] tval);
    logic [31:0] pend;
    hit   = 1'b0;
    cause = '0;
    epc   = '0;
    tval  = '0;
    for (int i = 8; i >= 0; i--) begin
      if (!hit && ex_strobes[i]) begin
        hit   = 1'b1;
        cause = {28'd0, ex_code_of(i)};
        tval  = (i >= 5) ? bad_addr : ((i == 3 || i == 2) ? 32'd0 : pc);
        epc   = (i == 4 || i == 3) ? pc + 32'd4 : pc;  // ebreak and ecall skip ahead.
      end
    end
    pend = m_mip & m_mie;
    if (!hit && m_gie && pend != 32'd0) begin
      hit = 1'b1;
      epc = pc;
      if (pend[prv_pkg::MIP_MTIP_BIT]) begin
        cause = {1'b1, 27'd0, prv_pkg::CAUSE_MTI};
      end else if (pend[prv_pkg::MIP_MSIP_BIT]) begin
        cause = {1'b1, 27'd0, prv_pkg::CAUSE_MSI};
      end else begin
        cause = {1'b1, 27'd0, prv_pkg::CAUSE_MEI};
      end
    end
    epc = {epc[31:2], 2'b00};
  endtask

  function automatic logic [31:0] expected_read(input logic [11:0] addr);
    case (addr)
      prv_pkg::CSR_MSTATUS: return {19'd0, 2'b11, 3'd0, m_mpie, 3'd0, m_gie, 3'd0};
      prv_pkg::CSR_MIE:     return m_mie;
      prv_pkg::CSR_MTVEC:   return m_mtvec;
      prv_pkg::CSR_MEPC:    return m_mepc;
      prv_pkg::CSR_MCAUSE:  return m_mcause;
      prv_pkg::CSR_MTVAL:   return m_mtval;
      prv_pkg::CSR_MIP:     return m_mip;
      default:              return 32'd0;
    endcase
  endfunction

  // Called at the rising edge with the inputs the DUT samples there.
  task automatic update_model();
    logic        hit;
    logic [31:0] cause;
    logic [31:0] epc;
    logic [31:0] tval;
    predict_trap(hit, cause, epc, tval);
    if (rst) begin
      m_gie    = 1'b0;
      m_mpie   = 1'b0;
      m_mie    = '0;
      m_mip    = '0;
      m_mtvec  = 32'h0000_0100;
      m_mepc   = '0;
      m_mcause = '0;
      m_mtval  = '0;
    end else begin
      if (hit) begin
        m_mcause = cause;
        m_mepc   = epc;
        m_mtval  = tval;
        m_mpie   = m_gie;
        m_gie    = 1'b0;
      end else begin
        if (ret) begin
          m_gie  = m_mpie;
          m_mpie = 1'b1;
        end
        if (csr_we) begin
          case (csr_addr)
            prv_pkg::CSR_MSTATUS: begin
              if (!ret) begin
                m_gie  = csr_wdata[3];
                m_mpie = csr_wdata[7];
              end
            end
            prv_pkg::CSR_MIE:    m_mie    = csr_wdata & IRQ_MASK;
            prv_pkg::CSR_MTVEC:  m_mtvec  = csr_wdata & ~32'd3;
            prv_pkg::CSR_MEPC:   m_mepc   = csr_wdata & ~32'd3;
            prv_pkg::CSR_MCAUSE: m_mcause = csr_wdata;
            prv_pkg::CSR_MTVAL:  m_mtval  = csr_wdata;
            default: ;
          endcase
        end
      end
      m_mip = {20'd0, int_lines[2], 3'd0, int_lines[0], 3'd0, int_lines[1], 3'd0};
    end
  endtask

  task automatic pick_strobe(output logic [8:0] s);
    logic [31:0] r;
    draw_bits(4, r);
    s = 9'd1 << (r % 32'd9);
  endtask

  task automatic drive_cycle(input int cyc);
    logic [31:0] r;
    logic [31:0] pick;
    logic [31:0] pc_n;
    logic [31:0] bad_n;
    logic [31:0] wdata_n;
    logic [8:0]  strobes_n;
    logic [2:0]  lines_n;
    logic [11:0] addr_n;
    logic        ret_n;
    logic        we_n;
    strobes_n = '0;
    lines_n   = int_lines;  // Interrupt lines are levels and hold by default.
    ret_n     = 1'b0;
    we_n      = 1'b0;
    draw_bits(32, pc_n);
    draw_bits(32, bad_n);
    draw_bits(32, wdata_n);
    draw_bits(3, pick);
    addr_n = csr_addr_of(pick[2:0]);
    if (cyc < 8) begin
      addr_n = csr_addr_of(cyc[2:0]);  // Quiet sweep of the reset values.
    end else begin
      draw_bits(4, r);
      if (r[3:0] == 4'd8) begin
        draw_bits(9, pick);
        strobes_n = pick[8:0];
      end else if (r[3:0] >= 4'd5 && r[3:0] <= 4'd7) begin
        pick_strobe(strobes_n);
      end else if (r[3:0] == 4'd9 || r[3:0] == 4'd10) begin
        draw_bits(3, pick);
        lines_n = pick[2:0];
      end else if (r[3:0] == 4'd11 || r[3:0] == 4'd12) begin
        ret_n = 1'b1;
        draw_bits(3, pick);
        we_n = pick[0];
        if (pick[2:1] == 2'b00) pick_strobe(strobes_n);
      end else if (r[3:0] >= 4'd13) begin
        we_n = 1'b1;
        draw_bits(2, pick);
        if (pick[1:0] == 2'b00) pick_strobe(strobes_n);
      end
    end
    ex_strobes <= strobes_n;
    int_lines  <= lines_n;
    pc         <= pc_n;
    bad_addr   <= bad_n;
    ret        <= ret_n;
    csr_we     <= we_n;
    csr_addr   <= addr_n;
    csr_wdata  <= wdata_n;
  endtask

  task automatic fail_run();
    $display("Testbench failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    fail_run();
  endtask

  task automatic check_outputs();
    logic        hit;
    logic [31:0] cause;
    logic [31:0] epc;
    logic [31:0] tval;
    logic [31:0] exp_rd;
    predict_trap(hit, cause, epc, tval);
    exp_rd = expected_read(csr_addr);
    assert (trap === hit)
      else report_mismatch($sformatf("trap is %0b, expected %0b", trap, hit));
    assert (trap_vector === m_mtvec)
      else report_mismatch($sformatf("trap_vector is %h, expected %h", trap_vector, m_mtvec));
    assert (ret_target === m_mepc)
      else report_mismatch($sformatf("ret_target is %h, expected %h", ret_target, m_mepc));
    assert (csr_rdata === exp_rd)
      else report_mismatch($sformatf("csr_rdata at %h is %h, expected %h",
                                     csr_addr, csr_rdata, exp_rd));
  endtask

  initial begin
    #((NUM_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Error: the test timed out before %0d cycles completed", NUM_CYCLES);
    fail_run();
  end

  initial begin
    lfsr       = SEED;
    rst        = 1'b1;
    int_lines  = '0;
    ex_strobes = '0;
    pc         = '0;
    bad_addr   = '0;
    ret        = 1'b0;
    csr_we     = 1'b0;
    csr_addr   = '0;
    csr_wdata  = '0;
    repeat (2) @(posedge clk);
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      update_model();
      rst <= 1'b0;
      drive_cycle(cyc);
      @(negedge clk);
      check_outputs();
      @(posedge clk);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/prv_block.sv
//############################################################################
// Machine-mode trap unit top level.
// Connects the interrupt and exception arbiters to the trap controller.
//############################################################################

`default_nettype none

module prv_block (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       timer_int,
  input  logic                       soft_int,
  input  logic                       ext_int,
  input  logic                       fault_l,
  input  logic                       mal_l,
  input  logic                       fault_s,
  input  logic                       mal_s,
  input  logic                       breakpoint,
  input  logic                       env_m,
  input  logic                       illegal_insn,
  input  logic                       fault_insn,
  input  logic                       mal_insn,
  input  logic [prv_pkg::XLEN-1:0]   pc,
  input  logic [prv_pkg::XLEN-1:0]   bad_addr,
  input  logic                       ret,
  input  logic                       csr_we,
  input  logic [11:0]                csr_addr,
  input  logic [prv_pkg::XLEN-1:0]   csr_wdata,
  output logic                       trap,
  output logic [prv_pkg::XLEN-1:0]   trap_vector,
  output logic [prv_pkg::XLEN-1:0]   ret_target,
  output logic [prv_pkg::XLEN-1:0]   csr_rdata
);

  logic                     int_req;
  logic [3:0]               int_cause;
  logic [prv_pkg::XLEN-1:0] mip;
  logic                     global_ie;
  logic [prv_pkg::XLEN-1:0] mie_bits;
  logic                     ex_req;
  logic [3:0]               ex_cause;
  logic [prv_pkg::XLEN-1:0] ex_tval;
  logic [prv_pkg::XLEN-1:0] ex_epc;

  prv_int_arbiter int_arb_i (
    .clk       (clk),
    .rst       (rst),
    .timer_int (timer_int),
    .soft_int  (soft_int),
    .ext_int   (ext_int),
    .mie_bits  (mie_bits),
    .global_ie (global_ie),
    .mip       (mip),
    .int_req   (int_req),
    .int_cause (int_cause)
  );

  prv_ex_arbiter ex_arb_i (
    .fault_l      (fault_l),
    .mal_l        (mal_l),
    .fault_s      (fault_s),
    .mal_s        (mal_s),
    .breakpoint   (breakpoint),
    .env_m        (env_m),
    .illegal_insn (illegal_insn),
    .fault_insn   (fault_insn),
    .mal_insn     (mal_insn),
    .pc           (pc),
    .bad_addr     (bad_addr),
    .ex_req       (ex_req),
    .ex_cause     (ex_cause),
    .ex_tval      (ex_tval),
    .ex_epc       (ex_epc)
  );

  prv_trap_ctrl trap_ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .int_req     (int_req),
    .ex_req      (ex_req),
    .ret         (ret),
    .csr_we      (csr_we),
    .int_cause   (int_cause),
    .ex_cause    (ex_cause),
    .mip         (mip),
    .ex_tval     (ex_tval),
    .ex_epc      (ex_epc),
    .pc          (pc),
    .csr_wdata   (csr_wdata),
    .csr_addr    (csr_addr),
    .global_ie   (global_ie),
    .mie_bits    (mie_bits),
    .trap        (trap),
    .trap_vector (trap_vector),
    .ret_target  (ret_target),
    .csr_rdata   (csr_rdata)
  );

endmodule

`default_nettype wire

//--- verilog/prv_trap_ctrl.sv
//############################################################################
// Trap controller.
// Merges the exception and interrupt requests into the trap strobe, keeps
// mstatus, mie, mtvec, mepc, mcause and mtval, handles mret and serves the
// CSR read and write port.
//############################################################################

`default_nettype none

module prv_trap_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       int_req,
  input  logic                       ex_req,
  input  logic                       ret,
  input  logic                       csr_we,
  input  logic [3:0]                 int_cause,
  input  logic [3:0]                 ex_cause,
  input  logic [prv_pkg::XLEN-1:0]   mip,
  input  logic [prv_pkg::XLEN-1:0]   ex_tval,
  input  logic [prv_pkg::XLEN-1:0]   ex_epc,
  input  logic [prv_pkg::XLEN-1:0]   pc,
  input  logic [prv_pkg::XLEN-1:0]   csr_wdata,
  input  logic [11:0]                csr_addr,
  output logic                       global_ie,
  output logic [prv_pkg::XLEN-1:0]   mie_bits,
  output logic                       trap,
  output logic [prv_pkg::XLEN-1:0]   trap_vector,
  output logic [prv_pkg::XLEN-1:0]   ret_target,
  output logic [prv_pkg::XLEN-1:0]   csr_rdata
);

  logic                     mstatus_mie;
  logic                     mstatus_mpie;
  logic                     mie_msie;
  logic                     mie_mtie;
  logic                     mie_meie;
  logic [prv_pkg::XLEN-1:0] mtvec;
  logic [prv_pkg::XLEN-1:0] mepc;
  logic [prv_pkg::XLEN-1:0] mcause;
  logic [prv_pkg::XLEN-1:0] mtval;
  logic [prv_pkg::XLEN-1:0] mstatus_rd;
  logic [3:0]               trap_cause;
  logic [prv_pkg::XLEN-1:0] trap_epc;

  // The interrupt arbiter already applied global_ie, so int_req is final.
  assign trap       = ex_req | int_req;
  assign trap_cause = ex_req ? ex_cause : int_cause;  // Exceptions win.
  assign trap_epc   = ex_req ? ex_epc : pc;

  assign global_ie   = mstatus_mie;
  assign trap_vector = mtvec;
  assign ret_target  = mepc;

  always_comb begin
    mie_bits                        = '0;
    mie_bits[prv_pkg::MIP_MSIP_BIT] = mie_msie;
    mie_bits[prv_pkg::MIP_MTIP_BIT] = mie_mtie;
    mie_bits[prv_pkg::MIP_MEIP_BIT] = mie_meie;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
      mie_msie     <= 1'b0;
      mie_mtie     <= 1'b0;
      mie_meie     <= 1'b0;
      mtvec        <= prv_pkg::MTVEC_RESET;
      mepc         <= '0;
      mcause       <= '0;
      mtval        <= '0;
    end else if (trap) begin
      // Trap entry drops any mret or CSR write in the same cycle.
      mcause       <= {~ex_req, {(prv_pkg::XLEN-5){1'b0}}, trap_cause};
      mepc         <= {trap_epc[prv_pkg::XLEN-1:2], 2'b00};
      mtval        <= ex_req ? ex_tval : '0;
      mstatus_mpie <= mstatus_mie;
      mstatus_mie  <= 1'b0;
    end else begin
      if (ret) begin
        mstatus_mie  <= mstatus_mpie;
        mstatus_mpie <= 1'b1;
      end
      if (csr_we) begin
        case (csr_addr)
          prv_pkg::CSR_MSTATUS: begin
            if (!ret) begin  // mret owns mstatus when both arrive.
              mstatus_mie  <= csr_wdata[prv_pkg::MSTATUS_MIE_BIT];
              mstatus_mpie <= csr_wdata[prv_pkg::MSTATUS_MPIE_BIT];
            end
          end
          prv_pkg::CSR_MIE: begin
            mie_msie <= csr_wdata[prv_pkg::MIP_MSIP_BIT];
            mie_mtie <= csr_wdata[prv_pkg::MIP_MTIP_BIT];
            mie_meie <= csr_wdata[prv_pkg::MIP_MEIP_BIT];
          end
          prv_pkg::CSR_MTVEC:  mtvec  <= {csr_wdata[prv_pkg::XLEN-1:2], 2'b00};
          prv_pkg::CSR_MEPC:   mepc   <= {csr_wdata[prv_pkg::XLEN-1:2], 2'b00};
          prv_pkg::CSR_MCAUSE: mcause <= csr_wdata;
          prv_pkg::CSR_MTVAL:  mtval  <= csr_wdata;
          default: ;  // mip and unknown addresses ignore writes.
        endcase
      end
    end
  end

  always_comb begin
    mstatus_rd                                          = '0;
    mstatus_rd[prv_pkg::MSTATUS_MIE_BIT]                = mstatus_mie;
    mstatus_rd[prv_pkg::MSTATUS_MPIE_BIT]               = mstatus_mpie;
    mstatus_rd[prv_pkg::MSTATUS_MPP_LSB +: 2]           = prv_pkg::PRV_M;
  end

  // Read data is combinational and shows the values before this edge.
  always_comb begin
    case (csr_addr)
      prv_pkg::CSR_MSTATUS: csr_rdata = mstatus_rd;
      prv_pkg::CSR_MIE:     csr_rdata = mie_bits;
      prv_pkg::CSR_MTVEC:   csr_rdata = mtvec;
      prv_pkg::CSR_MEPC:    csr_rdata = mepc;
      prv_pkg::CSR_MCAUSE:  csr_rdata = mcause;
      prv_pkg::CSR_MTVAL:   csr_rdata = mtval;
      prv_pkg::CSR_MIP:     csr_rdata = mip;
      default:              csr_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/prv_ex_arbiter.sv
//############################################################################
// Exception arbiter.
// Picks the winning exception strobe by fixed priority and supplies its
// cause code, trap value and the return address for mepc.
//############################################################################

`default_nettype none

module prv_ex_arbiter (
  input  logic                       fault_l,
  input  logic                       mal_l,
  input  logic                       fault_s,
  input  logic                       mal_s,
  input  logic                       breakpoint,
  input  logic                       env_m,
  input  logic                       illegal_insn,
  input  logic                       fault_insn,
  input  logic                       mal_insn,
  input  logic [prv_pkg::XLEN-1:0]   pc,
  input  logic [prv_pkg::XLEN-1:0]   bad_addr,
  output logic                       ex_req,
  output logic [3:0]                 ex_cause,
  output logic [prv_pkg::XLEN-1:0]   ex_tval,
  output logic [prv_pkg::XLEN-1:0]   ex_epc
);

  logic epc_p4;  // Return past the instruction instead of retrying it.

  always_comb begin
    ex_req   = 1'b1;
    ex_cause = prv_pkg::CAUSE_INSN_MAL;
    ex_tval  = pc;
    epc_p4   = 1'b0;
    if (fault_l) begin
      ex_cause = prv_pkg::CAUSE_LOAD_FAULT;
      ex_tval  = bad_addr;
    end else if (mal_l) begin
      ex_cause = prv_pkg::CAUSE_LOAD_MAL;
      ex_tval  = bad_addr;
    end else if (fault_s) begin
      ex_cause = prv_pkg::CAUSE_STORE_FAULT;
      ex_tval  = bad_addr;
    end else if (mal_s) begin
      ex_cause = prv_pkg::CAUSE_STORE_MAL;
      ex_tval  = bad_addr;
    end else if (breakpoint) begin
      ex_cause = prv_pkg::CAUSE_BREAKPOINT;
      epc_p4   = 1'b1;  // ebreak resumes at the next instruction.
    end else if (env_m) begin
      ex_cause = prv_pkg::CAUSE_ECALL_M;
      ex_tval  = '0;
      epc_p4   = 1'b1;  // So does ecall.
    end else if (illegal_insn) begin
      ex_cause = prv_pkg::CAUSE_ILLEGAL;
      ex_tval  = '0;
    end else if (fault_insn) begin
      ex_cause = prv_pkg::CAUSE_INSN_FAULT;
    end else if (mal_insn) begin
      ex_cause = prv_pkg::CAUSE_INSN_MAL;
    end else begin
      ex_req  = 1'b0;
      ex_tval = '0;
    end
  end

  assign ex_epc = epc_p4 ? pc + {{(prv_pkg::XLEN-3){1'b0}}, 3'd4} : pc;

endmodule

`default_nettype wire

//--- verilog/prv_int_arbiter.sv
//############################################################################
// Interrupt arbiter.
// Registers the timer, software and external interrupt lines into mip and
// picks the highest-priority pending interrupt that is enabled.
//############################################################################

`default_nettype none

module prv_int_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       timer_int,
  input  logic                       soft_int,
  input  logic                       ext_int,
  input  logic [prv_pkg::XLEN-1:0]   mie_bits,
  input  logic                       global_ie,
  output logic [prv_pkg::XLEN-1:0]   mip,
  output logic                       int_req,
  output logic [3:0]                 int_cause
);

  logic [prv_pkg::XLEN-1:0] pending;

  // mip follows the lines with one cycle of delay and is never written by
  // software, so every bit other than the three pending flags stays zero.
  always_ff @(posedge clk) begin
    if (rst) begin
      mip <= '0;
    end else begin
      mip                        <= '0;
      mip[prv_pkg::MIP_MTIP_BIT] <= timer_int;  // Timer pending.
      mip[prv_pkg::MIP_MSIP_BIT] <= soft_int;   // Software pending.
      mip[prv_pkg::MIP_MEIP_BIT] <= ext_int;    // External pending.
    end
  end

  assign pending = mip & mie_bits;  // Individually enabled pending bits.

  // Fixed order is timer, then software, then external.
  always_comb begin
    int_req   = 1'b0;
    int_cause = prv_pkg::CAUSE_MTI;
    if (global_ie) begin
      if (pending[prv_pkg::MIP_MTIP_BIT]) begin
        int_req   = 1'b1;
        int_cause = prv_pkg::CAUSE_MTI;
      end else if (pending[prv_pkg::MIP_MSIP_BIT]) begin
        int_req   = 1'b1;
        int_cause = prv_pkg::CAUSE_MSI;
      end else if (pending[prv_pkg::MIP_MEIP_BIT]) begin
        int_req   = 1'b1;
        int_cause = prv_pkg::CAUSE_MEI;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/prv_pkg.sv
//############################################################################
// Machine-mode trap unit package.
// Holds the data width, CSR addresses, trap cause codes, CSR bit positions
// and reset values shared by the arbiters and the trap controller.
//############################################################################

`default_nettype none

package prv_pkg;

  // Data and address width of the core.
  localparam int XLEN = 32;

  // Machine-mode trap CSR addresses.
  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MIE     = 12'h304;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;
  localparam logic [11:0] CSR_MTVAL   = 12'h343;
  localparam logic [11:0] CSR_MIP     = 12'h344;

  // Interrupt cause codes. Bit 31 of mcause marks them as interrupts.
  localparam logic [3:0] CAUSE_MSI = 4'd3;   // Machine software interrupt.
  localparam logic [3:0] CAUSE_MTI = 4'd7;   // Machine timer interrupt.
  localparam logic [3:0] CAUSE_MEI = 4'd11;  // Machine external interrupt.

  // Exception cause codes.
  localparam logic [3:0] CAUSE_INSN_MAL    = 4'd0;
  localparam logic [3:0] CAUSE_INSN_FAULT  = 4'd1;
  localparam logic [3:0] CAUSE_ILLEGAL     = 4'd2;
  localparam logic [3:0] CAUSE_BREAKPOINT  = 4'd3;
  localparam logic [3:0] CAUSE_LOAD_MAL    = 4'd4;
  localparam logic [3:0] CAUSE_LOAD_FAULT  = 4'd5;
  localparam logic [3:0] CAUSE_STORE_MAL   = 4'd6;
  localparam logic [3:0] CAUSE_STORE_FAULT = 4'd7;
  localparam logic [3:0] CAUSE_ECALL_M     = 4'd11;

  // Field positions inside mstatus.
  localparam int MSTATUS_MIE_BIT  = 3;   // Global machine interrupt enable.
  localparam int MSTATUS_MPIE_BIT = 7;   // Enable saved on trap entry.
  localparam int MSTATUS_MPP_LSB  = 11;  // Low bit of the 2-bit mpp field.

  // Pending bit positions inside mip. The mie register uses the same ones.
  localparam int MIP_MSIP_BIT = 3;
  localparam int MIP_MTIP_BIT = 7;
  localparam int MIP_MEIP_BIT = 11;

  // Handler address after reset, direct mode only.
  localparam logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100;

  // Machine privilege code, the only mode this unit supports.
  localparam logic [1:0] PRV_M = 2'b11;

endpackage

`default_nettype wire
